// ==== hw/tp84_macros.svh ====
//========================================
// TP84 video constants
// Widths, raster windows and bus register map
//========================================
`ifndef TP84_MACROS_SVH
`define TP84_MACROS_SVH

// Pixel enable divider
`define TP84_PIX_DIV     8
`define TP84_DIV_W       3

// Beam counter widths and limits
`define TP84_H_W         9
`define TP84_V_W         8
`define TP84_H_FIRST     9'd128
`define TP84_H_LAST      9'd511
`define TP84_V_LAST      8'd255

// Blanking windows (hblank uses open bounds)
`define TP84_HBLK_LO     9'd137
`define TP84_HBLK_HI     9'd269
`define TP84_VBLK_LO     8'd240
`define TP84_VBLK_HI     8'd16

// Sync pulses, low across the inclusive range
`define TP84_HS_LO       9'd184
`define TP84_HS_HI       9'd215
`define TP84_VS_LO       8'd248
`define TP84_VS_HI       8'd255

// Playfield and HUD windows on the h count
`define TP84_SCROLL_LO   9'd271
`define TP84_SCROLL_HI   9'd496
`define TP84_HUD_BOT_LO  9'd504
`define TP84_HUD_BOT_HI  9'd138
`define TP84_HUD_TOP_LO  9'd507
`define TP84_HUD_TOP_HI  9'd284

// Bus register map
`define TP84_AXI_AW      12
`define TP84_REG_CTRL    12'h000
`define TP84_REG_COLOR   12'h004
`define TP84_REG_XSCROLL 12'h008
`define TP84_REG_YSCROLL 12'h00C
`define TP84_PAL_BASE    12'h400
`define TP84_PAL_DEPTH   256
`define TP84_RESP_OKAY   2'b00
`define TP84_RD_UNMAPPED 32'h0000_00FF

`endif

// ==== hw/tp84_pkg.sv ====
//========================================
// TP84 video shared types
// Beam, control, palette, pixel and bus structs
//========================================
`include "tp84_macros.svh"

package tp84_pkg;

	//========================================
	// Raster and control
	//========================================

	// Beam position, h runs 128..511
	typedef struct packed {
		logic [`TP84_H_W-1:0] h;
		logic [`TP84_V_W-1:0] v;
	} beam_t;

	// Latched video control from the host
	typedef struct packed {
		logic       irq_en;
		logic       vflip;
		logic       hflip;
		logic [4:0] color;
		logic [7:0] xscroll;
		logic [7:0] yscroll;
	} vid_ctrl_t;

	// Timing flags, blanking active high and syncs active low
	typedef struct packed {
		logic hblank;
		logic vblank;
		logic hsync_n;
		logic vsync_n;
		logic pix_en;
	} sync_t;

	//========================================
	// Pixel path
	//========================================

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// One palette write, valid for a single clock
	typedef struct packed {
		logic       we;
		logic [7:0] idx;
		rgb_t       rgb;
	} pal_wr_t;

	// Sprite bit 4 set means transparent
	typedef struct packed {
		logic [3:0] tile;
		logic [4:0] spr;
	} pix_in_t;

	//========================================
	// AXI4-Lite
	//========================================

	typedef struct packed {
		logic                    awvalid;
		logic [`TP84_AXI_AW-1:0] awaddr;
		logic                    wvalid;
		logic [31:0]             wdata;
		logic [3:0]              wstrb;
		logic                    bready;
		logic                    arvalid;
		logic [`TP84_AXI_AW-1:0] araddr;
		logic                    rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

// ==== hw/tp84_bus_regs.sv ====
//========================================
// TP84 bus registers
// AXI4-Lite slave for control latches and palette
// Also holds the VBlank interrupt flop
//========================================
`timescale 1ns/1ps
`include "tp84_macros.svh"

module tp84_bus_regs (
	input  logic                clk_49m,
	input  logic                mirq_mask,
	input  tp84_pkg::axil_req_t axil_req_i,
	output tp84_pkg::axil_rsp_t axil_rsp_o,
	input  logic                vblank_rise_i,
	output tp84_pkg::vid_ctrl_t ctrl_o,
	output tp84_pkg::pal_wr_t   pal_wr_o,
	output logic                irq_o
);
	import tp84_pkg::*;

	vid_ctrl_t               ctrl_q;
	logic                    wr_acc;
	logic                    rd_acc;
	logic                    bvalid_q;
	logic                    rvalid_q;
	logic [31:0]             rdata_d;
	logic [31:0]             rdata_q;
	logic                    irq_q;
	logic                    pal_hit;
	logic [`TP84_AXI_AW-1:0] waddr;
	logic [31:0]             wdata;

	assign waddr = axil_req_i.awaddr;
	assign wdata = axil_req_i.wdata;

	// Write needs both channels together and no response outstanding
	assign wr_acc = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
	// Read blocked while the previous data waits for RREADY
	assign rd_acc = axil_req_i.arvalid & ~rvalid_q;

	//========================================
	// Control latches
	//========================================

	// Byte lane 0 carries every register
	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask) begin
			ctrl_q <= '0;
		end else if (wr_acc && axil_req_i.wstrb[0]) begin
			case (waddr)
				`TP84_REG_CTRL: begin
					ctrl_q.irq_en <= wdata[0];
					ctrl_q.vflip  <= wdata[1];
					ctrl_q.hflip  <= wdata[2];
				end
				`TP84_REG_COLOR:   ctrl_q.color   <= wdata[4:0];
				`TP84_REG_XSCROLL: ctrl_q.xscroll <= wdata[7:0];
				`TP84_REG_YSCROLL: ctrl_q.yscroll <= wdata[7:0];
				default: ;
			endcase
		end
	end

	assign ctrl_o = ctrl_q;

	// Palette window is 0x400..0x7FF, one word per entry
	assign pal_hit = ({waddr[11:10], 10'h000} == `TP84_PAL_BASE);

	// Strobe goes out in the accept cycle, 12-bit word needs lanes 0 and 1
	assign pal_wr_o.we  = wr_acc & pal_hit & (&axil_req_i.wstrb[1:0]);
	assign pal_wr_o.idx = waddr[9:2];
	assign pal_wr_o.rgb = wdata[11:0];

	//========================================
	// Responses
	//========================================

	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (axil_req_i.bready)
				bvalid_q <= 1'b0;
			if (rd_acc)
				rvalid_q <= 1'b1;
			else if (axil_req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

	// Readback zero-extended, palette and holes read as open bus
	always_comb begin
		case (axil_req_i.araddr)
			`TP84_REG_CTRL:    rdata_d = {29'd0, ctrl_q.hflip, ctrl_q.vflip, ctrl_q.irq_en};
			`TP84_REG_COLOR:   rdata_d = {27'd0, ctrl_q.color};
			`TP84_REG_XSCROLL: rdata_d = {24'd0, ctrl_q.xscroll};
			`TP84_REG_YSCROLL: rdata_d = {24'd0, ctrl_q.yscroll};
			default:           rdata_d = `TP84_RD_UNMAPPED;
		endcase
	end

	always_ff @(posedge clk_49m) begin
		if (rd_acc)
			rdata_q <= rdata_d;
	end

	assign axil_rsp_o.awready = wr_acc;
	assign axil_rsp_o.wready  = wr_acc;
	assign axil_rsp_o.bvalid  = bvalid_q;
	assign axil_rsp_o.bresp   = `TP84_RESP_OKAY;
	assign axil_rsp_o.arready = rd_acc;
	assign axil_rsp_o.rvalid  = rvalid_q;
	assign axil_rsp_o.rdata   = rdata_q;
	assign axil_rsp_o.rresp   = `TP84_RESP_OKAY;

	//========================================
	// VBlank interrupt
	//========================================

	// Pending edge is dropped while masked so it cannot fire late
	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask)
			irq_q <= 1'b0;
		else if (!ctrl_q.irq_en)
			irq_q <= 1'b0;
		else if (vblank_rise_i)
			irq_q <= 1'b1;
	end

	// Clearing irq_en takes the line down at once
	assign irq_o = irq_q & ctrl_q.irq_en;

endmodule

// ==== hw/tp84_video_timing.sv ====
//========================================
// TP84 video timing
// Pixel enable, beam counters, blanking and syncs
//========================================
`timescale 1ns/1ps
`include "tp84_macros.svh"

module tp84_video_timing (
	input  logic            clk_49m,
	input  logic            mirq_mask,
	output tp84_pkg::beam_t beam_o,
	output tp84_pkg::sync_t sync_o,
	output logic            vblank_rise_o
);
	import tp84_pkg::*;

	logic [`TP84_DIV_W-1:0] div_q;
	logic                   pix_en;
	beam_t                  beam_q;
	logic                   hblank;
	logic                   vblank;
	logic                   vblank_q;

	// Divide clk_49m down to the pixel rate
	assign pix_en = (div_q == `TP84_DIV_W'(`TP84_PIX_DIV - 1));

	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask)
			div_q <= '0;
		else if (pix_en)
			div_q <= '0;
		else
			div_q <= div_q + 1'b1;
	end

	// h runs 128..511 then steps v
	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask) begin
			beam_q.h <= `TP84_H_FIRST;
			beam_q.v <= '0;
		end else if (pix_en) begin
			if (beam_q.h == `TP84_H_LAST) begin
				beam_q.h <= `TP84_H_FIRST;
				if (beam_q.v == `TP84_V_LAST)
					beam_q.v <= '0;
				else
					beam_q.v <= beam_q.v + 1'b1;
			end else begin
				beam_q.h <= beam_q.h + 1'b1;
			end
		end
	end

	assign beam_o = beam_q;

	// Windows decoded straight off the registered beam
	assign hblank = (beam_q.h > `TP84_HBLK_LO) && (beam_q.h < `TP84_HBLK_HI);
	// vblank wraps through v = 0
	assign vblank = (beam_q.v >= `TP84_VBLK_LO) || (beam_q.v < `TP84_VBLK_HI);

	assign sync_o.hblank  = hblank;
	assign sync_o.vblank  = vblank;
	assign sync_o.hsync_n = ~((beam_q.h >= `TP84_HS_LO) && (beam_q.h <= `TP84_HS_HI));
	assign sync_o.vsync_n = ~((beam_q.v >= `TP84_VS_LO) && (beam_q.v <= `TP84_VS_HI));
	assign sync_o.pix_en  = pix_en;

	// Reset lands inside vblank, start high so no edge is seen
	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask)
			vblank_q <= 1'b1;
		else
			vblank_q <= vblank;
	end

	// One clock wide, first cycle of vblank
	assign vblank_rise_o = vblank & ~vblank_q;

endmodule

// ==== hw/tp84_tile_scroll.sv ====
//========================================
// TP84 tile address
// Flip and scroll applied to the tilemap address
//========================================
`timescale 1ns/1ps
`include "tp84_macros.svh"

module tp84_tile_scroll (
	input  tp84_pkg::beam_t     beam_i,
	input  tp84_pkg::vid_ctrl_t ctrl_i,
	output logic [10:0]         tile_addr_o
);

	logic       in_win;
	logic [7:2] h_flip;
	logic [7:0] v_flip;
	logic [7:2] h_scr;
	logic [7:0] v_scr;

	// Playfield scrolls, HUD columns outside it stay fixed
	assign in_win = (beam_i.h > `TP84_SCROLL_LO) && (beam_i.h < `TP84_SCROLL_HI);

	// Flip by inverting the counter bits
	assign h_flip = beam_i.h[7:2] ^ {6{ctrl_i.hflip}};
	assign v_flip = beam_i.v ^ {8{ctrl_i.vflip}};

	// Low two xscroll bits are the fine pixel shift, not part of the address
	assign h_scr = h_flip + (in_win ? ctrl_i.xscroll[7:2] : 6'd0);
	assign v_scr = v_flip + (in_win ? ctrl_i.yscroll : 8'd0);

	// HUD area in the upper half of the map
	assign tile_addr_o = {~in_win, v_scr[7:3], h_scr[7:3]};

endmodule

// ==== hw/tp84_pixel_out.sv ====
//========================================
// TP84 pixel output
// Tile/sprite priority, palette lookup, blanked RGB
//========================================
`timescale 1ns/1ps
`include "tp84_macros.svh"

module tp84_pixel_out (
	input  logic                clk_49m,
	input  logic                mirq_mask,
	input  tp84_pkg::beam_t     beam_i,
	input  tp84_pkg::sync_t     sync_i,
	input  tp84_pkg::vid_ctrl_t ctrl_i,
	input  tp84_pkg::pal_wr_t   pal_wr_i,
	input  tp84_pkg::pix_in_t   pix_i,
	output tp84_pkg::rgb_t      rgb_o
);
	import tp84_pkg::*;

	logic       bot_hud;
	logic       top_hud;
	logic       sel;
	logic [3:0] chosen;
	logic [4:0] pix_q;
	logic [7:0] pal_idx;
	rgb_t       pal_mem [`TP84_PAL_DEPTH];
	rgb_t       rgb_q;
	logic [1:0] blank_q;

	//========================================
	// Priority
	//========================================

	// HUD windows wrap through the h = 511 to 128 turn
	assign bot_hud = (beam_i.h > `TP84_HUD_BOT_LO) || (beam_i.h < `TP84_HUD_BOT_HI);
	assign top_hud = (beam_i.h > `TP84_HUD_TOP_LO) || (beam_i.h < `TP84_HUD_TOP_HI);

	// Tile wins in the HUD or behind a transparent sprite
	assign sel    = bot_hud | top_hud | pix_i.spr[4];
	assign chosen = sel ? pix_i.tile : pix_i.spr[3:0];

	// Stage 1 latch, select bit kept to pick the palette half
	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask)
			pix_q <= '0;
		else if (sync_i.pix_en)
			pix_q <= {sel, chosen};
	end

	//========================================
	// Palette
	//========================================

	// Tile and sprite halves, 8 banks of 16 from the colour latch
	assign pal_idx = {pix_q[4], ctrl_i.color[2:0], pix_q[3:0]};

	always_ff @(posedge clk_49m) begin
		if (pal_wr_i.we)
			pal_mem[pal_wr_i.idx] <= pal_wr_i.rgb;
	end

	// Stage 2 read
	always_ff @(posedge clk_49m) begin
		if (sync_i.pix_en)
			rgb_q <= pal_mem[pal_idx];
	end

	// Blank flags follow the pixel through both stages
	always_ff @(posedge clk_49m or negedge mirq_mask) begin
		if (!mirq_mask)
			blank_q <= 2'b11;
		else if (sync_i.pix_en)
			blank_q <= {blank_q[0], sync_i.hblank | sync_i.vblank};
	end

	assign rgb_o = blank_q[1] ? '0 : rgb_q;

endmodule

// ==== hw/tp84_video_top.sv ====
//========================================
// TP84 video top
// Bus registers, timing, tile address and pixel out
//========================================
`timescale 1ns/1ps

module tp84_video_top (
	input  logic                clk_49m,
	input  logic                mirq_mask,
	input  tp84_pkg::axil_req_t axil_req_i,
	output tp84_pkg::axil_rsp_t axil_rsp_o,
	input  tp84_pkg::pix_in_t   pix_i,
	output tp84_pkg::rgb_t      rgb_o,
	output tp84_pkg::sync_t     sync_o,
	output tp84_pkg::beam_t     beam_o,
	output logic [10:0]         tile_addr_o,
	output logic                irq_o
);
	import tp84_pkg::*;

	vid_ctrl_t ctrl;
	pal_wr_t   pal_wr;
	beam_t     beam;
	sync_t     sync;
	logic      vblank_rise;

	// Host side
	tp84_bus_regs u_bus_regs (
		.clk_49m      (clk_49m),
		.mirq_mask    (mirq_mask),
		.axil_req_i   (axil_req_i),
		.axil_rsp_o   (axil_rsp_o),
		.vblank_rise_i(vblank_rise),
		.ctrl_o       (ctrl),
		.pal_wr_o     (pal_wr),
		.irq_o        (irq_o)
	);

	// Raster counters
	tp84_video_timing u_timing (
		.clk_49m      (clk_49m),
		.mirq_mask    (mirq_mask),
		.beam_o       (beam),
		.sync_o       (sync),
		.vblank_rise_o(vblank_rise)
	);

	// Tilemap address out to the external fetch logic
	tp84_tile_scroll u_tile_scroll (
		.beam_i     (beam),
		.ctrl_i     (ctrl),
		.tile_addr_o(tile_addr_o)
	);

	tp84_pixel_out u_pixel_out (
		.clk_49m  (clk_49m),
		.mirq_mask(mirq_mask),
		.beam_i   (beam),
		.sync_i   (sync),
		.ctrl_i   (ctrl),
		.pal_wr_i (pal_wr),
		.pix_i    (pix_i),
		.rgb_o    (rgb_o)
	);

	// Beam exported for tile and sprite fetch
	assign beam_o = beam;
	assign sync_o = sync;

endmodule

// ==== tests/tb_clock_gen.sv ====
//========================================
// Testbench clock and reset
// 8 ns clock, reset low for 16 cycles
//========================================
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int RST_CYCLES = 16;

	// 125 MHz stand-in for the 49 MHz board clock
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// Release on a rising edge like every other input
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

// ==== tests/tb_tp84_video.sv ====
//========================================
// TP84 video testbench
// Table driven bus, palette, tile and IRQ checks
// Background monitor for beam, blanking and syncs
//========================================
`timescale 1ns/1ps
`include "tp84_macros.svh"

module tb_tp84_video;
	import tp84_pkg::*;

	localparam logic [1:0] OP_WR   = 2'd0;
	localparam logic [1:0] OP_RD   = 2'd1;
	localparam logic [1:0] OP_PIX  = 2'd2;
	localparam logic [1:0] OP_TILE = 2'd3;
	localparam int NROWS = 25;
	// One frame is 384 pixels by 256 lines at 8 clocks per pixel
	localparam int FRAME_CYC = (int'(`TP84_H_LAST) - int'(`TP84_H_FIRST) + 1)
		* (int'(`TP84_V_LAST) + 1) * `TP84_PIX_DIV;
	localparam int TIMEOUT_CYC = 3 * FRAME_CYC;

	// One stimulus row, h0 is the beam position for pixel and tile rows
	typedef struct packed {
		logic [1:0]  op;
		logic [11:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
		pix_in_t     pix;
		logic [8:0]  h0;
	} row_t;

	logic        clk_49m;
	logic        mirq_mask;
	axil_req_t   req;
	axil_rsp_t   rsp;
	pix_in_t     pix;
	rgb_t        rgb;
	sync_t       sync;
	beam_t       beam;
	logic [10:0] tile_addr;
	logic        irq;

	row_t        tbl [NROWS];
	rgb_t        pal_model [256];
	int          cycles = 0;
	logic [1:0]  blank_hist = 2'b11;
	logic        exp_hb;
	logic        exp_vb;

	// Beam model, steps once per pixel enable
	logic [8:0]  exp_h = `TP84_H_FIRST;
	logic [7:0]  exp_v = '0;
	int          div_cnt = 0;

	// Register shadow, updated as the testbench writes
	logic        sh_vflip = 1'b0;
	logic        sh_hflip = 1'b0;
	logic [4:0]  sh_color = '0;
	logic [7:0]  sh_xscroll = '0;
	logic [7:0]  sh_yscroll = '0;

	tb_clock_gen clkgen (
		.clk_o  (clk_49m),
		.rst_n_o(mirq_mask)
	);

	tp84_video_top UUT (
		.clk_49m    (clk_49m),
		.mirq_mask  (mirq_mask),
		.axil_req_i (req),
		.axil_rsp_o (rsp),
		.pix_i      (pix),
		.rgb_o      (rgb),
		.sync_o     (sync),
		.beam_o     (beam),
		.tile_addr_o(tile_addr),
		.irq_o      (irq)
	);

	//========================================
	// Reporting
	//========================================

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		stop_run($sformatf("ERROR at time %0t: %s is 0x%0h, expected 0x%0h",
			$time, what, got, exp));
	endtask

	//========================================
	// AXI4-Lite master
	//========================================

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
		@(posedge clk_49m);
		req.awvalid <= 1'b1;
		req.awaddr  <= addr;
		req.wvalid  <= 1'b1;
		req.wdata   <= data;
		req.wstrb   <= 4'hF;
		req.bready  <= 1'b1;
		do @(negedge clk_49m); while (!rsp.awready);
		assert (rsp.wready) else stop_run("WREADY did not pulse together with AWREADY");
		@(posedge clk_49m);
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		do @(negedge clk_49m); while (!rsp.bvalid);
		assert (rsp.bresp == `TP84_RESP_OKAY)
			else report_mismatch("bresp", 32'(rsp.bresp), 32'(`TP84_RESP_OKAY));
		@(posedge clk_49m);
		req.bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
		@(posedge clk_49m);
		req.arvalid <= 1'b1;
		req.araddr  <= addr;
		req.rready  <= 1'b1;
		do @(negedge clk_49m); while (!rsp.arready);
		@(posedge clk_49m);
		req.arvalid <= 1'b0;
		do @(negedge clk_49m); while (!rsp.rvalid);
		data = rsp.rdata;
		assert (rsp.rresp == `TP84_RESP_OKAY)
			else report_mismatch("rresp", 32'(rsp.rresp), 32'(`TP84_RESP_OKAY));
		@(posedge clk_49m);
		req.rready <= 1'b0;
	endtask

	// Register map as seen from the host
	task automatic shadow_write(input logic [11:0] addr, input logic [31:0] data);
		case (addr)
			`TP84_REG_CTRL: begin
				sh_vflip = data[1];
				sh_hflip = data[2];
			end
			`TP84_REG_COLOR:   sh_color = data[4:0];
			`TP84_REG_XSCROLL: sh_xscroll = data[7:0];
			`TP84_REG_YSCROLL: sh_yscroll = data[7:0];
			default: ;
		endcase
	endtask

	// Second write waits behind a held BVALID
	task automatic check_write_hold();
		logic [31:0] rd;
		@(posedge clk_49m);
		req.awvalid <= 1'b1;
		req.awaddr  <= `TP84_REG_XSCROLL;
		req.wvalid  <= 1'b1;
		req.wdata   <= 32'h44;
		req.wstrb   <= 4'hF;
		req.bready  <= 1'b0;
		do @(negedge clk_49m); while (!rsp.awready);
		@(posedge clk_49m);
		req.wdata <= 32'h99;
		repeat (6) begin
			@(negedge clk_49m);
			assert (rsp.bvalid) else stop_run("BVALID dropped while BREADY was low");
			assert (!rsp.awready) else stop_run("a second write was accepted during BVALID");
		end
		@(posedge clk_49m);
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		req.bready  <= 1'b1;
		@(posedge clk_49m);
		req.bready <= 1'b0;
		@(negedge clk_49m);
		assert (!rsp.bvalid) else stop_run("BVALID stayed high after the BREADY handshake");
		axi_read(`TP84_REG_XSCROLL, rd);
		assert (rd == 32'h44) else report_mismatch("xscroll after held write", rd, 32'h44);
		sh_xscroll = 8'h44;
	endtask

	//========================================
	// Reference rules
	//========================================

	function automatic logic hud_active(input logic [8:0] h);
		return (h > `TP84_HUD_BOT_LO) || (h < `TP84_HUD_BOT_HI)
			|| (h > `TP84_HUD_TOP_LO) || (h < `TP84_HUD_TOP_HI);
	endfunction

	// Out-of-window flag, then scrolled v and h tile rows
	function automatic logic [10:0] tile_expect(input logic [8:0] h, input logic [7:0] v);
		logic       outside;
		logic [5:0] hx;
		logic [7:0] vy;
		outside = !((h > `TP84_SCROLL_LO) && (h < `TP84_SCROLL_HI));
		hx = sh_hflip ? ~h[7:2] : h[7:2];
		vy = sh_vflip ? ~v : v;
		if (!outside) begin
			hx = hx + sh_xscroll[7:2];
			vy = vy + sh_yscroll;
		end
		return {outside, vy[7:3], hx[5:1]};
	endfunction

	function automatic row_t make_row(input logic [1:0] op, input logic [11:0] addr,
		input logic [31:0] data, input logic [31:0] exp, input logic [8:0] pixel,
		input logic [8:0] h0);
		row_t r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		r.pix  = pixel;
		r.h0   = h0;
		return r;
	endfunction

	task automatic wait_pix_en();
		do @(negedge clk_49m); while (!sync.pix_en);
		@(posedge clk_49m);
	endtask

	task automatic wait_vblank_rise();
		logic prev;
		@(negedge clk_49m);
		prev = sync.vblank;
		@(negedge clk_49m);
		while (prev || !sync.vblank) begin
			prev = sync.vblank;
			@(negedge clk_49m);
		end
	endtask

	//========================================
	// Monitors
	//========================================

	// Beam, windows and blanked RGB, checked on every cycle after reset
	always @(negedge clk_49m) begin
		if (mirq_mask) begin
			assert (beam.h == exp_h) else report_mismatch("beam h", 32'(beam.h), 32'(exp_h));
			assert (beam.v == exp_v) else report_mismatch("beam v", 32'(beam.v), 32'(exp_v));
			assert (sync.pix_en == (div_cnt == `TP84_PIX_DIV - 1))
				else stop_run("pix_en does not fire once every eight clocks");
			exp_hb = (beam.h > `TP84_HBLK_LO) && (beam.h < `TP84_HBLK_HI);
			exp_vb = (beam.v >= `TP84_VBLK_LO) || (beam.v < `TP84_VBLK_HI);
			assert (sync.hblank == exp_hb)
				else report_mismatch("hblank", 32'(sync.hblank), 32'(exp_hb));
			assert (sync.vblank == exp_vb)
				else report_mismatch("vblank", 32'(sync.vblank), 32'(exp_vb));
			assert (sync.hsync_n == !((beam.h >= `TP84_HS_LO) && (beam.h <= `TP84_HS_HI)))
				else stop_run("hsync_n does not match the h sync window");
			assert (sync.vsync_n == !((beam.v >= `TP84_VS_LO) && (beam.v <= `TP84_VS_HI)))
				else stop_run("vsync_n does not match the v sync window");
			// Blank two pixel enables back forces black
			if (blank_hist[1])
				assert (rgb == '0) else report_mismatch("rgb_o in blanking", 32'(rgb), 0);
			if (sync.pix_en)
				blank_hist = {blank_hist[0], exp_hb | exp_vb};
			// h wraps 511 to 128 and steps v, v rolls over past 255
			if (div_cnt == `TP84_PIX_DIV - 1) begin
				div_cnt = 0;
				if (exp_h == `TP84_H_LAST) begin
					exp_h = `TP84_H_FIRST;
					exp_v = exp_v + 1'b1;
				end else begin
					exp_h = exp_h + 1'b1;
				end
			end else begin
				div_cnt = div_cnt + 1;
			end
		end
	end

	always @(posedge clk_49m) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYC)
			stop_run("Timeout: the tests did not finish within three frames");
	end

	//========================================
	// Stimulus
	//========================================

	initial begin
		logic [31:0] rd;
		logic [31:0] wd;
		row_t        row;
		logic        sel;
		logic [3:0]  color;
		logic [7:0]  idx;

		req = '0;
		pix = '0;
		void'($urandom(32'hd81575f1));

		// Writes, masked readback, holes and palette reads
		tbl[0]  = make_row(OP_WR, `TP84_REG_CTRL, 32'hFE, 0, '0, '0);
		tbl[1]  = make_row(OP_WR, `TP84_REG_COLOR, 32'hFF, 0, '0, '0);
		tbl[2]  = make_row(OP_WR, `TP84_REG_XSCROLL, 32'h1A5, 0, '0, '0);
		tbl[3]  = make_row(OP_WR, `TP84_REG_YSCROLL, 32'hF3C, 0, '0, '0);
		tbl[4]  = make_row(OP_WR, 12'h020, 32'hDEADBEEF, 0, '0, '0);
		tbl[5]  = make_row(OP_RD, `TP84_REG_CTRL, 0, 32'h06, '0, '0);
		tbl[6]  = make_row(OP_RD, `TP84_REG_COLOR, 0, 32'h1F, '0, '0);
		tbl[7]  = make_row(OP_RD, `TP84_REG_XSCROLL, 0, 32'hA5, '0, '0);
		tbl[8]  = make_row(OP_RD, `TP84_REG_YSCROLL, 0, 32'h3C, '0, '0);
		tbl[9]  = make_row(OP_RD, 12'h020, 0, 32'hFF, '0, '0);
		tbl[10] = make_row(OP_RD, 12'h404, 0, 32'hFF, '0, '0);
		// Tile address with both flips, then unflipped
		tbl[11] = make_row(OP_TILE, 0, 0, 0, '0, 9'd320);
		tbl[12] = make_row(OP_TILE, 0, 0, 0, '0, 9'd500);
		tbl[13] = make_row(OP_TILE, 0, 0, 0, '0, 9'd200);
		tbl[14] = make_row(OP_WR, `TP84_REG_CTRL, 32'h0, 0, '0, '0);
		tbl[15] = make_row(OP_WR, `TP84_REG_XSCROLL, 32'h13, 0, '0, '0);
		tbl[16] = make_row(OP_TILE, 0, 0, 0, '0, 9'd300);
		tbl[17] = make_row(OP_TILE, 0, 0, 0, '0, 9'd140);
		// Priority: opaque, transparent, then HUD over opaque
		tbl[18] = make_row(OP_WR, `TP84_REG_COLOR, 32'h5, 0, '0, '0);
		tbl[19] = make_row(OP_PIX, 0, 0, 0, {4'h3, 5'h0A}, 9'd320);
		tbl[20] = make_row(OP_PIX, 0, 0, 0, {4'hC, 5'h1A}, 9'd400);
		tbl[21] = make_row(OP_PIX, 0, 0, 0, {4'h9, 5'h04}, 9'd272);
		tbl[22] = make_row(OP_PIX, 0, 0, 0, {4'h2, 5'h07}, 9'd506);
		tbl[23] = make_row(OP_WR, `TP84_REG_COLOR, 32'h3, 0, '0, '0);
		tbl[24] = make_row(OP_PIX, 0, 0, 0, {4'h5, 5'h0E}, 9'd450);

		@(posedge mirq_mask);
		repeat (2) @(posedge clk_49m);

		// Random palette contents
		for (int i = 0; i < 256; i++) begin
			wd = $urandom & 32'h0000_0FFF;
			axi_write(12'(`TP84_PAL_BASE + i * 4), wd);
			pal_model[i] = wd[11:0];
		end

		check_write_hold();

		for (int n = 0; n < NROWS; n++) begin
			row = tbl[n];
			case (row.op)
				OP_WR: begin
					axi_write(row.addr, row.data);
					shadow_write(row.addr, row.data);
				end
				OP_RD: begin
					axi_read(row.addr, rd);
					assert (rd == row.exp)
						else report_mismatch($sformatf("read of 0x%0h", row.addr), rd, row.exp);
				end
				OP_TILE: begin
					do @(negedge clk_49m); while (beam.h != row.h0);
					assert (tile_addr == tile_expect(beam.h, beam.v))
						else report_mismatch("tile_addr_o", 32'(tile_addr),
							32'(tile_expect(beam.h, beam.v)));
				end
				default: begin
					@(posedge clk_49m);
					pix <= row.pix;
					// Active line, away from blanking
					do @(negedge clk_49m);
					while (beam.h != row.h0 || beam.v < `TP84_VBLK_HI || beam.v >= `TP84_VBLK_LO);
					repeat (3) wait_pix_en();
					@(negedge clk_49m);
					sel   = hud_active(row.h0) || row.pix.spr[4];
					color = sel ? row.pix.tile : row.pix.spr[3:0];
					idx   = {sel, sh_color[2:0], color};
					assert (rgb == pal_model[idx])
						else report_mismatch("rgb_o", 32'(rgb), 32'(pal_model[idx]));
				end
			endcase
		end

		//========================================
		// VBlank interrupt
		//========================================

		axi_write(`TP84_REG_CTRL, 32'h1);
		wait_vblank_rise();
		assert (!irq) else stop_run("irq_o was high before vblank started");
		@(negedge clk_49m);
		if (!irq)
			@(negedge clk_49m);
		assert (irq) else stop_run("irq_o did not rise within two cycles of vblank");

		// Masking takes the line down with the write
		axi_write(`TP84_REG_CTRL, 32'h0);
		@(negedge clk_49m);
		assert (!irq) else stop_run("irq_o stayed high after irq_en was cleared");

		wait_vblank_rise();
		while (sync.vblank) begin
			assert (!irq) else stop_run("irq_o rose during vblank with irq_en clear");
			@(negedge clk_49m);
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== tp84_video.f ====
+incdir+hw
hw/tp84_pkg.sv
hw/tp84_bus_regs.sv
hw/tp84_video_timing.sv
hw/tp84_tile_scroll.sv
hw/tp84_pixel_out.sv
hw/tp84_video_top.sv
tests/tb_clock_gen.sv
tests/tb_tp84_video.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TP84 video testbench with Verilator
# Exit status is the simulator's, a failing run ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module tb_tp84_video \
	-f tp84_video.f \
	-o sim_tp84_video \
	&& ./obj_dir/sim_tp84_video \
	|| exit 1
